/* verilog/lsu_pkg.sv */
// ----------------------------
// Shared widths, AMO and size encodings,
// core and memory request and response structs
// ----------------------------

package lsu_pkg;

  localparam int unsigned AddrWidth    = 32;
  localparam int unsigned DataWidth    = 32;
  localparam int unsigned TagWidth     = 5;
  localparam int unsigned IdWidth      = 8;
  // Local ID sits in the low bits, the port index right above it
  localparam int unsigned LocalIdWidth = 4;
  localparam int unsigned MemWords     = 256;

  typedef enum logic [1:0] {
    AMO_NONE = 2'd0,
    AMO_SWAP = 2'd1,
    AMO_ADD  = 2'd2
  } amo_op_e;

  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } size_e;

  typedef struct packed {
    logic [TagWidth-1:0]  tag;
    logic                 write;
    logic                 sign_ext;
    logic [AddrWidth-1:0] addr;
    logic [DataWidth-1:0] data;
    size_e                size;
    amo_op_e              amo;
  } core_req_t;

  typedef struct packed {
    logic [TagWidth-1:0]  tag;
    logic [DataWidth-1:0] data;
    logic                 error;
  } core_rsp_t;

  // Address is the byte address with the two low bits cleared
  typedef struct packed {
    logic [AddrWidth-1:0]   addr;
    logic                   write;
    amo_op_e                amo;
    logic [DataWidth-1:0]   data;
    logic [DataWidth/8-1:0] strb;
    logic [IdWidth-1:0]     id;
  } mem_req_t;

  typedef struct packed {
    logic [DataWidth-1:0] data;
    logic                 error;
    logic [IdWidth-1:0]   id;
  } mem_rsp_t;

endpackage

/* verilog/lsu_unit.sv */
// ----------------------------
// Load/store unit with ID table for
// out-of-order responses, alignment and extension
// ----------------------------

module lsu_unit
  import lsu_pkg::*;
#(
  parameter int unsigned NumOutstanding = 4,
  parameter int unsigned PortIdx        = 0
) (
  input  logic      clk_i,
  input  logic      rst_i,
  // Core request
  input  core_req_t core_req_i,
  input  logic      core_req_valid_i,
  output logic      core_req_ready_o,
  // Core response
  output core_rsp_t core_rsp_o,
  output logic      core_rsp_valid_o,
  input  logic      core_rsp_ready_i,
  // Memory request
  output mem_req_t  mem_req_o,
  output logic      mem_req_valid_o,
  input  logic      mem_req_ready_i,
  // Memory response
  input  mem_rsp_t  mem_rsp_i,
  input  logic      mem_rsp_valid_i,
  output logic      mem_rsp_ready_o
);

  localparam int unsigned IdxW       = (NumOutstanding > 1) ? $clog2(NumOutstanding) : 1;
  localparam int unsigned PortFieldW = IdWidth - LocalIdWidth;

  typedef struct packed {
    logic                write;
    logic [TagWidth-1:0] tag;
    logic                sign_ext;
    logic [1:0]          offset;
    size_e               size;
  } meta_t;

  // ----------------------------
  // ID table
  // ----------------------------
  logic [NumOutstanding-1:0] id_available_d, id_available_q;
  meta_t [NumOutstanding-1:0] meta_d, meta_q;
  meta_t                     req_meta;
  meta_t                     rsp_meta;
  logic [IdxW-1:0]           req_id;
  logic [IdxW-1:0]           rsp_id;
  logic                      id_table_push;
  logic                      id_table_pop;
  logic                      id_table_full;
  logic                      rsp_mine;

  // Response data path
  logic [DataWidth-1:0]   rsp_shifted;
  logic [DataWidth-1:0]   ld_data;
  logic [2*DataWidth-1:0] wdata_rot;

  // AMO results always go back to the core
  assign req_meta = '{
    write:    core_req_i.write && (core_req_i.amo == AMO_NONE),
    tag:      core_req_i.tag,
    sign_ext: core_req_i.sign_ext,
    offset:   core_req_i.addr[1:0],
    size:     core_req_i.size
  };

  // Lowest free entry wins
  always_comb begin
    req_id = '0;
    for (int i = NumOutstanding - 1; i >= 0; i--) begin
      if (id_available_q[i]) begin
        req_id = IdxW'(i);
      end
    end
  end

  assign id_table_full = ~|id_available_q;
  assign id_table_push = mem_req_valid_o & mem_req_ready_i;
  assign id_table_pop  = mem_rsp_valid_i & mem_rsp_ready_o & rsp_mine;

  always_comb begin
    id_available_d = id_available_q;
    meta_d         = meta_q;
    if (id_table_push) begin
      id_available_d[req_id] = 1'b0;
      meta_d[req_id]         = req_meta;
    end
    if (id_table_pop) begin
      id_available_d[rsp_id] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      id_available_q <= '1;
    end else begin
      id_available_q <= id_available_d;
    end
  end

  always_ff @(posedge clk_i) begin
    meta_q <= meta_d;
  end

  // ----------------------------
  // Request
  // ----------------------------
  assign mem_req_valid_o = core_req_valid_i & ~id_table_full;
  assign core_req_ready_o = mem_req_ready_i & ~id_table_full;

  // Rotate write data left by the byte offset
  assign wdata_rot = {core_req_i.data, core_req_i.data} << {core_req_i.addr[1:0], 3'b000};

  always_comb begin
    mem_req_o.addr  = {core_req_i.addr[AddrWidth-1:2], 2'b00};
    mem_req_o.write = core_req_i.write;
    mem_req_o.amo   = core_req_i.amo;
    mem_req_o.data  = wdata_rot[2*DataWidth-1:DataWidth];
    mem_req_o.id    = IdWidth'(req_id);
    case (core_req_i.size)
      SIZE_BYTE: mem_req_o.strb = 4'b0001 << core_req_i.addr[1:0];
      SIZE_HALF: mem_req_o.strb = 4'b0011 << core_req_i.addr[1:0];
      SIZE_WORD: mem_req_o.strb = 4'b1111;
      default:   mem_req_o.strb = 4'b0000;
    endcase
  end

  // ----------------------------
  // Response
  // ----------------------------
  assign rsp_id   = mem_rsp_i.id[IdxW-1:0];
  assign rsp_meta = meta_q[rsp_id];
  // The crossbar tags every response with its port, stray ones are dropped
  assign rsp_mine = (mem_rsp_i.id[IdWidth-1:LocalIdWidth] == PortFieldW'(PortIdx));

  assign rsp_shifted = mem_rsp_i.data >> {rsp_meta.offset, 3'b000};

  always_comb begin
    case (rsp_meta.size)
      SIZE_BYTE: ld_data = {{24{rsp_shifted[7] & rsp_meta.sign_ext}}, rsp_shifted[7:0]};
      SIZE_HALF: ld_data = {{16{rsp_shifted[15] & rsp_meta.sign_ext}}, rsp_shifted[15:0]};
      default:   ld_data = rsp_shifted;
    endcase
  end

  assign core_rsp_o.tag   = rsp_meta.tag;
  assign core_rsp_o.data  = ld_data;
  assign core_rsp_o.error = mem_rsp_i.error;

  // Store responses are swallowed here
  assign core_rsp_valid_o = mem_rsp_valid_i & rsp_mine & ~rsp_meta.write;
  assign mem_rsp_ready_o  = core_rsp_ready_i | rsp_meta.write | ~rsp_mine;

endmodule

/* verilog/tcdm_xbar.sv */
// ----------------------------
// Round-robin request arbiter and
// ID-routed response demux
// ----------------------------

module tcdm_xbar
  import lsu_pkg::*;
#(
  parameter int unsigned NumPorts = 4
) (
  input  logic                clk_i,
  input  logic                rst_i,
  // Port side
  input  mem_req_t            port_req_i       [NumPorts],
  input  logic [NumPorts-1:0] port_req_valid_i,
  output logic [NumPorts-1:0] port_req_ready_o,
  output mem_rsp_t            port_rsp_o       [NumPorts],
  output logic [NumPorts-1:0] port_rsp_valid_o,
  input  logic [NumPorts-1:0] port_rsp_ready_i,
  // Memory side
  output mem_req_t            mem_req_o,
  output logic                mem_req_valid_o,
  input  logic                mem_req_ready_i,
  input  mem_rsp_t            mem_rsp_i,
  input  logic                mem_rsp_valid_i,
  output logic                mem_rsp_ready_o
);

  localparam int unsigned PortW      = (NumPorts > 1) ? $clog2(NumPorts) : 1;
  localparam int unsigned PortFieldW = IdWidth - LocalIdWidth;

  logic [PortW-1:0]      ptr_q;
  logic [PortW-1:0]      cand_idx;
  logic [PortW-1:0]      gnt_idx;
  logic                  gnt_found;
  logic [PortFieldW-1:0] rsp_port;
  logic                  rsp_port_ok;

  // ----------------------------
  // Request arbitration
  // ----------------------------
  // Search starts at the pointer and wraps around
  always_comb begin
    gnt_found = 1'b0;
    gnt_idx   = '0;
    cand_idx  = '0;
    for (int i = 0; i < NumPorts; i++) begin
      cand_idx = PortW'((int'(ptr_q) + i) % NumPorts);
      if (!gnt_found && port_req_valid_i[cand_idx]) begin
        gnt_found = 1'b1;
        gnt_idx   = cand_idx;
      end
    end
  end

  always_comb begin
    mem_req_o = port_req_i[gnt_idx];
    // Port index goes into the upper id bits
    mem_req_o.id[IdWidth-1:LocalIdWidth] = PortFieldW'(gnt_idx);
  end

  assign mem_req_valid_o = gnt_found;

  always_comb begin
    for (int p = 0; p < NumPorts; p++) begin
      port_req_ready_o[p] = mem_req_ready_i & gnt_found & (gnt_idx == PortW'(p));
    end
  end

  // Next search begins just past the port that was served
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      ptr_q <= '0;
    end else if (mem_req_valid_o && mem_req_ready_i) begin
      if (int'(gnt_idx) == NumPorts - 1) begin
        ptr_q <= '0;
      end else begin
        ptr_q <= gnt_idx + 1'b1;
      end
    end
  end

  // ----------------------------
  // Response routing
  // ----------------------------
  assign rsp_port    = mem_rsp_i.id[IdWidth-1:LocalIdWidth];
  assign rsp_port_ok = (int'(rsp_port) < NumPorts);

  always_comb begin
    for (int p = 0; p < NumPorts; p++) begin
      port_rsp_o[p]       = mem_rsp_i;
      port_rsp_valid_o[p] = mem_rsp_valid_i && (rsp_port == PortFieldW'(p));
    end
  end

  // Responses for a port that does not exist are drained
  assign mem_rsp_ready_o = rsp_port_ok ? port_rsp_ready_i[rsp_port[PortW-1:0]] : 1'b1;

endmodule

/* verilog/tcdm_mem.sv */
// ----------------------------
// Two-bank scratchpad with unequal bank
// latency and swap/add atomics
// ----------------------------

module tcdm_mem
  import lsu_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_i,
  input  mem_req_t req_i,
  input  logic     req_valid_i,
  output logic     req_ready_o,
  output mem_rsp_t rsp_o,
  output logic     rsp_valid_o,
  input  logic     rsp_ready_i
);

  localparam int unsigned WordIdxW = $clog2(MemWords);

  logic [DataWidth-1:0] mem_q [MemWords];
  logic [WordIdxW-1:0]  word_idx;
  logic                 bank_sel;
  logic [DataWidth-1:0] old_word;
  logic [DataWidth-1:0] new_word;
  logic [DataWidth-1:0] strb_mask;
  logic                 accept;
  logic                 mem_we;
  mem_rsp_t             acc_rsp;

  // Response stages
  logic       b0_valid_q;
  mem_rsp_t   b0_rsp_q;
  logic [2:0] b1_valid_q;
  mem_rsp_t   b1_rsp_q [3];
  logic       b0_pop;
  logic       b1_pop;
  logic       b0_free;
  logic       b1_stall;

  // ----------------------------
  // Array access
  // ----------------------------
  assign word_idx = req_i.addr[2 +: WordIdxW];
  // Word address bit 0 picks the bank
  assign bank_sel = req_i.addr[2];
  assign old_word = mem_q[word_idx];

  always_comb begin
    for (int b = 0; b < DataWidth / 8; b++) begin
      strb_mask[8*b +: 8] = {8{req_i.strb[b]}};
    end
  end

  always_comb begin
    case (req_i.amo)
      AMO_SWAP: new_word = req_i.data;
      AMO_ADD:  new_word = old_word + req_i.data;
      default:  new_word = (old_word & ~strb_mask) | (req_i.data & strb_mask);
    endcase
  end

  assign accept  = req_valid_i & req_ready_o;
  assign mem_we  = accept & (req_i.write | (req_i.amo != AMO_NONE));
  assign acc_rsp = '{data: old_word, error: 1'b0, id: req_i.id};

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      for (int i = 0; i < MemWords; i++) begin
        mem_q[i] <= '0;
      end
    end else if (mem_we) begin
      mem_q[word_idx] <= new_word;
    end
  end

  // ----------------------------
  // Response pipelines
  // ----------------------------
  // Bank 0 has priority at the output
  assign b0_pop   = b0_valid_q & rsp_ready_i;
  assign b1_pop   = b1_valid_q[2] & ~b0_valid_q & rsp_ready_i;
  assign b0_free  = ~b0_valid_q | b0_pop;
  assign b1_stall = b1_valid_q[2] & ~b1_pop;

  assign req_ready_o = b0_free & ~b1_stall;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      b0_valid_q <= 1'b0;
      b1_valid_q <= '0;
    end else begin
      if (accept && !bank_sel) begin
        b0_valid_q <= 1'b1;
      end else if (b0_pop) begin
        b0_valid_q <= 1'b0;
      end
      if (!b1_stall) begin
        b1_valid_q <= {b1_valid_q[1:0], accept & bank_sel};
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept && !bank_sel) begin
      b0_rsp_q <= acc_rsp;
    end
    if (!b1_stall) begin
      b1_rsp_q[0] <= acc_rsp;
      b1_rsp_q[1] <= b1_rsp_q[0];
      b1_rsp_q[2] <= b1_rsp_q[1];
    end
  end

  assign rsp_o       = b0_valid_q ? b0_rsp_q : b1_rsp_q[2];
  assign rsp_valid_o = b0_valid_q | b1_valid_q[2];

endmodule

/* verilog/lsu_cluster.sv */
// ----------------------------
// Cluster top with per-port LSUs,
// crossbar and scratchpad
// ----------------------------

module lsu_cluster
  import lsu_pkg::*;
#(
  parameter int unsigned NumPorts       = 4,
  parameter int unsigned NumOutstanding = 4
) (
  input  logic                clk_i,
  input  logic                rst_i,
  input  core_req_t           core_req_i       [NumPorts],
  input  logic [NumPorts-1:0] core_req_valid_i,
  output logic [NumPorts-1:0] core_req_ready_o,
  output core_rsp_t           core_rsp_o       [NumPorts],
  output logic [NumPorts-1:0] core_rsp_valid_o,
  input  logic [NumPorts-1:0] core_rsp_ready_i
);

  // LSU to crossbar
  mem_req_t            lsu_req       [NumPorts];
  logic [NumPorts-1:0] lsu_req_valid;
  logic [NumPorts-1:0] lsu_req_ready;
  mem_rsp_t            lsu_rsp       [NumPorts];
  logic [NumPorts-1:0] lsu_rsp_valid;
  logic [NumPorts-1:0] lsu_rsp_ready;

  // Crossbar to memory
  mem_req_t mem_req;
  logic     mem_req_valid;
  logic     mem_req_ready;
  mem_rsp_t mem_rsp;
  logic     mem_rsp_valid;
  logic     mem_rsp_ready;

  for (genvar p = 0; p < NumPorts; p++) begin : gen_lsu
    lsu_unit #(
      .NumOutstanding(NumOutstanding),
      .PortIdx       (p)
    ) lsu_unit_inst (
      .clk_i           (clk_i),
      .rst_i           (rst_i),
      .core_req_i      (core_req_i[p]),
      .core_req_valid_i(core_req_valid_i[p]),
      .core_req_ready_o(core_req_ready_o[p]),
      .core_rsp_o      (core_rsp_o[p]),
      .core_rsp_valid_o(core_rsp_valid_o[p]),
      .core_rsp_ready_i(core_rsp_ready_i[p]),
      .mem_req_o       (lsu_req[p]),
      .mem_req_valid_o (lsu_req_valid[p]),
      .mem_req_ready_i (lsu_req_ready[p]),
      .mem_rsp_i       (lsu_rsp[p]),
      .mem_rsp_valid_i (lsu_rsp_valid[p]),
      .mem_rsp_ready_o (lsu_rsp_ready[p])
    );
  end

  tcdm_xbar #(
    .NumPorts(NumPorts)
  ) tcdm_xbar_inst (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .port_req_i      (lsu_req),
    .port_req_valid_i(lsu_req_valid),
    .port_req_ready_o(lsu_req_ready),
    .port_rsp_o      (lsu_rsp),
    .port_rsp_valid_o(lsu_rsp_valid),
    .port_rsp_ready_i(lsu_rsp_ready),
    .mem_req_o       (mem_req),
    .mem_req_valid_o (mem_req_valid),
    .mem_req_ready_i (mem_req_ready),
    .mem_rsp_i       (mem_rsp),
    .mem_rsp_valid_i (mem_rsp_valid),
    .mem_rsp_ready_o (mem_rsp_ready)
  );

  tcdm_mem tcdm_mem_inst (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .req_i      (mem_req),
    .req_valid_i(mem_req_valid),
    .req_ready_o(mem_req_ready),
    .rsp_o      (mem_rsp),
    .rsp_valid_o(mem_rsp_valid),
    .rsp_ready_i(mem_rsp_ready)
  );

endmodule

/* test/lsu_cluster_properties.sv */
// ----------------------------
// Handshake and ID table assertions for lsu_unit
// ----------------------------

module lsu_cluster_properties
  import lsu_pkg::*;
#(
  parameter int unsigned NumOutstanding = 4
) (
  input logic                                    clk_i,
  input logic                                    rst_i,
  input logic                                    req_valid_i,
  input logic                                    req_ready_i,
  input core_req_t                               req_bits_i,
  input logic                                    push_i,
  input logic                                    pop_i,
  input logic [NumOutstanding-1:0]               avail_i,
  input logic [$clog2(NumOutstanding > 1 ? NumOutstanding : 2)-1:0] push_id_i,
  input logic [$clog2(NumOutstanding > 1 ? NumOutstanding : 2)-1:0] pop_id_i,
  input logic                                    rsp_valid_i
);

  // Plain store per ID, taken from the core request
  logic [NumOutstanding-1:0] store_q;

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      store_q[push_id_i] <= req_bits_i.write && (req_bits_i.amo == AMO_NONE);
    end
  end

  // Held request stays put until accepted
  req_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    req_valid_i && !req_ready_i |=> req_valid_i && $stable(req_bits_i))
    else $error("core request changed before acceptance");

  push_free: assert property (@(posedge clk_i) disable iff (rst_i)
    push_i |-> avail_i[push_id_i])
    else $error("push to an occupied ID");

  pop_busy: assert property (@(posedge clk_i) disable iff (rst_i)
    pop_i |-> !avail_i[pop_id_i])
    else $error("pop of a free ID");

  no_write_rsp: assert property (@(posedge clk_i) disable iff (rst_i)
    rsp_valid_i |-> !store_q[pop_id_i])
    else $error("core response for a write");

endmodule

bind lsu_unit lsu_cluster_properties #(
  .NumOutstanding(NumOutstanding)
) lsu_cluster_properties_inst (
  .clk_i         (clk_i),
  .rst_i         (rst_i),
  .req_valid_i   (core_req_valid_i),
  .req_ready_i   (core_req_ready_o),
  .req_bits_i    (core_req_i),
  .push_i        (id_table_push),
  .pop_i         (id_table_pop),
  .avail_i       (id_available_q),
  .push_id_i     (req_id),
  .pop_id_i      (rsp_id),
  .rsp_valid_i   (core_rsp_valid_o)
);

/* test/lsu_cluster_tb.sv */
// ----------------------------
// Cluster testbench with reference memory model
// ----------------------------

module lsu_cluster_tb
  import lsu_pkg::*;
();

  localparam int NP = 4;
  localparam int NO = 4;
  localparam int TO = 200;

  logic          clk_i;
  logic          rst_i;
  core_req_t     core_req   [NP];
  logic [NP-1:0] req_valid;
  logic [NP-1:0] req_ready;
  core_rsp_t     core_rsp   [NP];
  logic [NP-1:0] rsp_valid;
  logic [NP-1:0] rsp_ready;

  // Reference model state
  logic [31:0] model_mem [MemWords];
  logic [31:0] exp_data  [NP][32];
  bit          busy      [NP][32];
  logic [31:0] last_data [NP];
  int          acc_count [NP];
  int unsigned seed = 62478;
  int          errors = 0;
  int          test_errors = 0;
  int          tests = 0;
  int          checks = 0;
  bit          traffic_on;

  lsu_cluster #(
    .NumPorts      (NP),
    .NumOutstanding(NO)
  ) lsu_cluster_inst (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .core_req_i      (core_req),
    .core_req_valid_i(req_valid),
    .core_req_ready_o(req_ready),
    .core_rsp_o      (core_rsp),
    .core_rsp_valid_o(rsp_valid),
    .core_rsp_ready_i(rsp_ready)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  function automatic int unsigned lcg();
    seed = seed * 32'd1103515245 + 32'd12345;
    return {16'h0, seed[30:15]};
  endfunction

  // Load result as the core should see it
  function automatic logic [31:0] extract(logic [31:0] w, logic [1:0] off, size_e sz, logic sx);
    logic [31:0] s;
    s = w >> (off * 8);
    case (sz)
      SIZE_BYTE: return sx ? {{24{s[7]}}, s[7:0]} : {24'h0, s[7:0]};
      SIZE_HALF: return sx ? {{16{s[15]}}, s[15:0]} : {16'h0, s[15:0]};
      default:   return s;
    endcase
  endfunction

  task automatic check32(string name, logic [31:0] got, logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
      errors++;
      test_errors++;
    end
  endtask

  task automatic note_error(string msg);
    $display("ERROR at %0t: %s", $time, msg);
    errors++;
    test_errors++;
  endtask

  task automatic end_test(string name);
    tests++;
    $display("test %s: %s", name, (test_errors == 0) ? "ok" : "mismatches");
    test_errors = 0;
  endtask

  // ----------------------------
  // Model update and response check
  // ----------------------------
  always @(negedge clk_i) begin : monitor
    core_req_t   r;
    logic [31:0] old;
    logic [31:0] nw;
    int          n;
    for (int p = 0; p < NP; p++) begin
      if (req_valid[p] && req_ready[p]) begin
        r   = core_req[p];
        old = model_mem[r.addr[9:2]];
        nw  = old;
        n   = (r.size == SIZE_BYTE) ? 1 : (r.size == SIZE_HALF) ? 2 : 4;
        for (int b = 0; b < 4; b++) begin
          if (b >= int'(r.addr[1:0]) && b < int'(r.addr[1:0]) + n) begin
            nw[8*b +: 8] = r.data[8*(b-int'(r.addr[1:0])) +: 8];
          end
        end
        acc_count[p]++;
        if (r.amo == AMO_SWAP) model_mem[r.addr[9:2]] = r.data;
        else if (r.amo == AMO_ADD) model_mem[r.addr[9:2]] = old + r.data;
        else if (r.write) model_mem[r.addr[9:2]] = nw;
        if (r.amo != AMO_NONE) exp_data[p][r.tag] = old;
        else if (!r.write) exp_data[p][r.tag] = extract(old, r.addr[1:0], r.size, r.sign_ext);
      end
      if (rsp_valid[p] && rsp_ready[p]) begin
        if (!busy[p][core_rsp[p].tag]) begin
          note_error($sformatf("port %0d response with unknown tag %0d", p, core_rsp[p].tag));
        end else begin
          check32($sformatf("core_rsp_o[%0d].data", p), core_rsp[p].data,
                  exp_data[p][core_rsp[p].tag]);
        end
        // No bus errors exist in this cluster
        check32($sformatf("core_rsp_o[%0d].error", p), 32'(core_rsp[p].error), 32'h0);
        busy[p][core_rsp[p].tag] = 1'b0;
        last_data[p] = core_rsp[p].data;
      end
    end
  end

  // ----------------------------
  // Stimulus tasks
  // ----------------------------
  task automatic issue(int p, logic wr, logic sx, logic [31:0] addr, logic [31:0] data,
                       size_e sz, amo_op_e amo, logic [4:0] tag);
    int n;
    if (!wr || amo != AMO_NONE) busy[p][tag] = 1'b1;
    @(posedge clk_i);
    core_req[p] <= '{tag: tag, write: wr, sign_ext: sx, addr: addr, data: data,
                     size: sz, amo: amo};
    req_valid[p] <= 1'b1;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while (!(req_valid[p] && req_ready[p]) && n < TO);
    if (n >= TO) note_error($sformatf("port %0d request never accepted", p));
    @(posedge clk_i);
    req_valid[p] <= 1'b0;
  endtask

  task automatic drain(int p);
    int n;
    bit any;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
      any = 1'b0;
      for (int t = 0; t < 32; t++) any |= busy[p][t];
    end while (any && n < TO);
    if (any) note_error($sformatf("port %0d responses missing", p));
  endtask

  task automatic access(logic wr, logic sx, logic [31:0] addr, logic [31:0] data,
                        size_e sz, amo_op_e amo);
    issue(1, wr, sx, addr, data, sz, amo, 5'd3);
    drain(1);
  endtask

  task automatic port_traffic(int p, int count);
    int unsigned k;
    int unsigned op;
    int unsigned word;
    logic [1:0]  off;
    size_e       sz;
    logic [4:0]  tag;
    tag = '0;
    for (int i = 0; i < count; i++) begin
      word = (lcg() % 64) * 4 + p;
      op   = lcg() % 6;
      k    = lcg() % 3;
      // Atomics always work on a whole aligned word
      sz   = (op >= 4) ? SIZE_WORD : (k == 0) ? SIZE_BYTE : (k == 1) ? SIZE_HALF : SIZE_WORD;
      off  = (sz == SIZE_BYTE) ? 2'(lcg()) : (sz == SIZE_HALF) ? {1'(lcg()), 1'b0} : 2'b00;
      while (busy[p][tag]) tag = tag + 5'd1;
      issue(p, op == 2 || op == 3, 1'(lcg()), word * 4 + off, lcg() * 32'd40503, sz,
            (op == 4) ? AMO_SWAP : (op == 5) ? AMO_ADD : AMO_NONE, tag);
      tag = tag + 5'd1;
    end
  endtask

  // ----------------------------
  // Test sequence
  // ----------------------------
  initial begin
    for (int p = 0; p < NP; p++) begin
      core_req[p]  = '0;
      last_data[p] = '0;
      acc_count[p] = 0;
      for (int t = 0; t < 32; t++) busy[p][t] = 1'b0;
    end
    for (int i = 0; i < MemWords; i++) model_mem[i] = '0;
    req_valid = '0;
    rsp_ready = '1;
    rst_i     = 1'b1;
    repeat (3) @(posedge clk_i);
    rst_i <= 1'b0;

    @(negedge clk_i);
    check32("core_rsp_valid_o", 32'(rsp_valid), 32'h0);
    access(1'b0, 1'b0, 32'h4, 32'h0, SIZE_WORD, AMO_NONE);
    check32("load after reset", last_data[1], 32'h0);
    end_test("reset");

    access(1'b1, 1'b0, 32'h14, 32'h11223344, SIZE_WORD, AMO_NONE);
    access(1'b0, 1'b0, 32'h14, 32'h0, SIZE_WORD, AMO_NONE);
    check32("word load", last_data[1], 32'h11223344);
    access(1'b1, 1'b0, 32'h15, 32'h000000aa, SIZE_BYTE, AMO_NONE);
    access(1'b1, 1'b0, 32'h16, 32'h0000beef, SIZE_HALF, AMO_NONE);
    access(1'b0, 1'b0, 32'h14, 32'h0, SIZE_WORD, AMO_NONE);
    check32("lane merge", last_data[1], 32'hbeefaa44);
    end_test("store_load");

    for (int s = 0; s < 2; s++) begin
      for (int o = 0; o < 4; o++) begin
        access(1'b0, 1'(s), 32'h14 + o, 32'h0, SIZE_BYTE, AMO_NONE);
        check32("byte load", last_data[1], extract(32'hbeefaa44, 2'(o), SIZE_BYTE, 1'(s)));
        if (o < 3) begin
          access(1'b0, 1'(s), 32'h14 + o, 32'h0, SIZE_HALF, AMO_NONE);
          check32("half load", last_data[1], extract(32'hbeefaa44, 2'(o), SIZE_HALF, 1'(s)));
        end
      end
    end
    end_test("extend");

    access(1'b0, 1'b0, 32'h24, 32'h5, SIZE_WORD, AMO_SWAP);
    check32("swap old", last_data[1], 32'h0);
    access(1'b0, 1'b0, 32'h24, 32'h7, SIZE_WORD, AMO_ADD);
    check32("add old", last_data[1], 32'h5);
    access(1'b0, 1'b0, 32'h24, 32'h0, SIZE_WORD, AMO_NONE);
    check32("amo result", last_data[1], 32'hc);
    end_test("amo");

    traffic_on = 1'b1;
    fork
      begin
        fork
          port_traffic(0, 60);
          port_traffic(1, 60);
          port_traffic(2, 60);
          port_traffic(3, 60);
        join
        traffic_on = 1'b0;
      end
      while (traffic_on) begin
        @(posedge clk_i);
        rsp_ready <= NP'(lcg());
      end
    join
    @(posedge clk_i);
    rsp_ready <= '1;
    for (int p = 0; p < NP; p++) drain(p);
    end_test("random");

    // Stall port 1 responses and keep loading bank 1 words
    @(posedge clk_i);
    rsp_ready[1] <= 1'b0;
    acc_count[1] = 0;
    fork
      for (int i = 0; i < NO + 2; i++) begin
        issue(1, 1'b0, 1'b0, 32'h4 + 32'(i) * 32'h20, 32'h0, SIZE_WORD, AMO_NONE, 5'(8 + i));
      end
      begin
        repeat (40) @(negedge clk_i);
        // A load must still be waiting at the port
        check32("core_req_valid_i[1]", 32'(req_valid[1]), 32'h1);
        check32("core_req_ready_o[1]", 32'(req_ready[1]), 32'h0);
        if (acc_count[1] > NO) note_error("more requests accepted than IDs");
        @(posedge clk_i);
        rsp_ready[1] <= 1'b1;
      end
    join
    drain(1);
    check32("accepted loads", 32'(acc_count[1]), 32'(NO + 2));
    end_test("backpressure");

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* vlog.f */
verilog/lsu_pkg.sv
verilog/lsu_unit.sv
verilog/tcdm_xbar.sv
verilog/tcdm_mem.sv
verilog/lsu_cluster.sv
test/lsu_cluster_properties.sv
test/lsu_cluster_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the cluster testbench with Verilator
verilator --binary --timing --assert --top-module lsu_cluster_tb -f vlog.f -o sim_lsu \
  && ./obj_dir/sim_lsu > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1 || exit 0
